// File: tart_correlator.f
+incdir+testbench
rtl/vis_pkg.sv
rtl/quadrature_frontend.sv
rtl/bank_switch.sv
rtl/correlator_block.sv
rtl/visibility_readout.sv
rtl/tart_correlator.sv
testbench/tb_tart_correlator.sv

// File: Makefile
TOP := tb_tart_correlator

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tart_correlator.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -Mdir obj_dir \
		-f tart_correlator.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: testbench/tb_vis_model.svh
   // ------------------------------------------------
   // Reference model of the correlator
   // ------------------------------------------------
   localparam int PAIR_A [BLOCK_COUNT][PAIRS_PER_BLOCK] = '{'{0, 0, 0}, '{1, 1, 2}};
   localparam int PAIR_B [BLOCK_COUNT][PAIRS_PER_BLOCK] = '{'{1, 2, 3}, '{2, 3, 3}};

   vis_t     acc_re  [BLOCK_COUNT][PAIRS_PER_BLOCK];   // Running real sums
   vis_t     acc_im  [BLOCK_COUNT][PAIRS_PER_BLOCK];   // Running imaginary sums
   vis_t     bank_re [BLOCK_COUNT][PAIRS_PER_BLOCK];   // Readout bank, real
   vis_t     bank_im [BLOCK_COUNT][PAIRS_PER_BLOCK];   // Readout bank, imaginary
   antenna_t prev_re;                                   // Last valid sample
   int       sample_count;                              // Valid samples this bank
   bank_t    model_bank;                                // Toggles per closed bank

   function automatic void model_reset();
      for (int blk = 0; blk < BLOCK_COUNT; blk++) begin
         for (int p = 0; p < PAIRS_PER_BLOCK; p++) begin
            acc_re[blk][p]  = '0;
            acc_im[blk][p]  = '0;
            bank_re[blk][p] = '0;
            bank_im[blk][p] = '0;
         end
      end
      prev_re      = '0;                  // im is 0 before first sample
      sample_count = 0;
      model_bank   = 1'b0;
   endfunction

   // One valid sample, products use the previous sample as im
   function automatic void model_sample(input antenna_t d);
      int   a;
      int   b;
      bit   closes;
      vis_t re_sum;
      vis_t im_sum;
      sample_count = sample_count + 1;
      closes       = (sample_count == BANK_SUMS);   // Last sample of the bank
      for (int blk = 0; blk < BLOCK_COUNT; blk++) begin
         for (int p = 0; p < PAIRS_PER_BLOCK; p++) begin
            a      = PAIR_A[blk][p];
            b      = PAIR_B[blk][p];
            re_sum = acc_re[blk][p] + vis_t'(d[a] == d[b]);
            im_sum = acc_im[blk][p] + vis_t'(d[a] == prev_re[b]);
            if (closes) begin
               bank_re[blk][p] = re_sum;  // Bank holds the closing sample too
               bank_im[blk][p] = im_sum;
               acc_re[blk][p]  = '0;
               acc_im[blk][p]  = '0;
            end else begin
               acc_re[blk][p]  = re_sum;
               acc_im[blk][p]  = im_sum;
            end
         end
      end
      if (closes) begin
         sample_count = 0;
         model_bank   = ~model_bank;
      end
      prev_re = d;
   endfunction

   // Address {blk, pair[1:0], imag}
   function automatic vis_t model_read(input vis_addr_t a);
      int blk;
      int p;
      blk = int'(a[3]);
      p   = int'(a[2:1]);
      if (p == 3) return '0;              // Unused pair slot
      return a[0] ? bank_im[blk][p] : bank_re[blk][p];
   endfunction

// File: testbench/tb_tart_correlator.sv
module tb_tart_correlator;

   import vis_pkg::*;

   localparam int ACCUM_W    = ACCUM_W_DEFAULT;
   localparam int PERIOD     = 4;
   localparam int BANK_SUMS  = 20;         // Valid samples per bank
   localparam int BANKS      = 5;          // Tests 2 to 4
   localparam int MAX_GAP    = 3;          // Idle cycles before a sample
   localparam int READS      = 16 + BANKS * 12 + 12;
   localparam int READ_CYC   = 12;         // Worst case with longest hold
   localparam int LIMIT_CYC  = 2 * (BANKS * (BANK_SUMS * (MAX_GAP + 1) + 4)
                                    + READS * READ_CYC) + 20;

   typedef logic [ACCUM_W-1:0] vis_t;

   logic         clk = 1'b0;
   logic         reset;
   logic         en;
   antenna_t     data;
   vis_t         sums;
   logic         swap;
   bank_t        bank;
   logic         req;
   vis_addr_t    addr;
   logic         ack;
   vis_t         dat;
   logic [15:0]  lfsr_q = 16'd78;       // Stimulus seed

   `include "tb_vis_model.svh"

   tart_correlator #(.ACCUM_W(ACCUM_W)) uut (
      .clk_i   (clk),
      .reset_i (reset),
      .data_i  (data),
      .en_i    (en),
      .sums_i  (sums),
      .swap_o  (swap),
      .bank_o  (bank),
      .req_i   (req),
      .addr_i  (addr),
      .ack_o   (ack),
      .dat_o   (dat)
   );

   always #(PERIOD / 2) clk = ~clk;

   // ------------------------------------------------
   // Random bits and failure handling
   // ------------------------------------------------
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);  // Galois step
         r      = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   task automatic fail_run();
      $display("Errors found");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic fail_with_reason(input string reason);
      $display("%s", reason);
      fail_run();
   endtask

   task automatic compare_vis(input string test, input vis_t expected, input vis_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %0d actual %0d", test, expected, actual);
         fail_run();
      end
   endtask

   task automatic compare_bank(input string test, input bank_t expected, input bank_t actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %0d actual %0d", test, expected, actual);
         fail_run();
      end
   endtask

   initial begin
      #(LIMIT_CYC * PERIOD);
      fail_with_reason($sformatf("Watchdog timeout after %0d cycles, the run hung", LIMIT_CYC));
   end

   // ------------------------------------------------
   // Stimulus tasks
   // ------------------------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;                                 // Drive and sample off the edge
   endtask

   task automatic send_bank(input bit with_gaps);
      int gap;
      for (int s = 0; s < BANK_SUMS; s++) begin
         gap = with_gaps ? int'(random_bits(2)) : 0;
         repeat (gap) begin
            next_cycle();
            en   = 1'b0;
            data = antenna_t'(random_bits(ANT_COUNT));  // Must be ignored
         end
         next_cycle();
         en   = 1'b1;
         data = antenna_t'(random_bits(ANT_COUNT));
         model_sample(data);
      end
      next_cycle();
      en = 1'b0;
   endtask

   task automatic wait_swap(input string test);
      int waited;
      waited = 0;
      while (!swap) begin
         next_cycle();
         waited++;
         if (waited > 4) fail_with_reason({test, ": swap_o never rose"});
      end
      compare_bank(test, model_bank, bank);
      next_cycle();
      if (swap) fail_with_reason({test, ": swap_o stayed high for more than one cycle"});
   endtask

   // Four-phase read with req held for hold extra cycles after ack
   task automatic read_vis(input string test, input vis_addr_t a, input int hold);
      next_cycle();
      req  = 1'b1;
      addr = a;
      next_cycle();
      if (ack) fail_with_reason({test, ": ack_o rose one cycle after req_i"});
      next_cycle();
      if (!ack) fail_with_reason({test, ": ack_o missing two cycles after req_i"});
      compare_vis(test, model_read(a), dat);
      repeat (hold) begin
         next_cycle();
         if (!ack) fail_with_reason({test, ": ack_o dropped while req_i was high"});
         compare_vis({test, " held"}, model_read(a), dat);   // Data frozen in ack phase
      end
      req = 1'b0;
      next_cycle();
      if (ack) fail_with_reason({test, ": ack_o still high after req_i fell"});
   endtask

   task automatic read_all(input string test, input bit skip_unused);
      vis_addr_t a;
      for (int i = 0; i < 16; i++) begin
         a = vis_addr_t'(i);
         if (skip_unused && a[2:1] == 2'b11) continue;
         read_vis($sformatf("%s addr %0h", test, a), a, 0);
      end
   endtask

   // ------------------------------------------------
   // Test sequence
   // ------------------------------------------------
   initial begin
      reset = 1'b1;
      en    = 1'b0;
      data  = '0;
      sums  = vis_t'(BANK_SUMS);
      req   = 1'b0;
      addr  = '0;
      model_reset();
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      compare_bank("reset bank", 1'b0, bank);           // 1. Reset state
      if (swap || ack) fail_with_reason("swap_o or ack_o high after reset");
      read_all("reset", 1'b0);

      send_bank(1'b0);                                  // 2. One bank
      wait_swap("one bank");
      read_all("one bank", 1'b1);

      send_bank(1'b1);                                  // 3. Enable gaps
      wait_swap("gaps");
      read_all("gaps", 1'b1);

      for (int k = 0; k < 3; k++) begin                 // 4. Repeated banks
         send_bank(1'b1);
         wait_swap($sformatf("repeat %0d", k));
         read_all($sformatf("repeat %0d", k), 1'b1);
      end

      for (int b = 0; b < BLOCK_COUNT; b++) begin       // 5. Handshake
         read_vis($sformatf("pair 3 re block %0d", b), {b[0], 2'b11, 1'b0},
                  int'(random_bits(3)));
         read_vis($sformatf("pair 3 im block %0d", b), {b[0], 2'b11, 1'b1},
                  int'(random_bits(3)));
      end
      for (int r = 0; r < 8; r++) begin
         addr = vis_addr_t'(random_bits(4));
         read_vis($sformatf("held read %0d", r), addr, int'(random_bits(3)) + 1);
      end

      $display("No errors");
      $finish;
   end

endmodule

// File: rtl/tart_correlator.sv
module tart_correlator #(
   parameter int ACCUM_W = vis_pkg::ACCUM_W_DEFAULT
) (
   input  logic               clk_i,
   input  logic               reset_i,
   // Antenna samples
   input  vis_pkg::antenna_t  data_i,
   input  logic               en_i,
   input  logic [ACCUM_W-1:0] sums_i,    // Valid samples per bank
   // Swap status
   output logic               swap_o,    // One-cycle pulse per bank
   output vis_pkg::bank_t     bank_o,
   // Read-back port
   input  logic               req_i,
   input  vis_pkg::vis_addr_t addr_i,
   output logic               ack_o,
   output logic [ACCUM_W-1:0] dat_o
);

   import vis_pkg::*;

   logic               valid;            // Front end sample strobe
   sample_t            sample;           // Real and delayed imaginary
   logic               swap;             // Closing sample of a bank
   vis_sel_t           sel;              // Readout entry select
   logic [ACCUM_W-1:0] blk0_vis;
   logic [ACCUM_W-1:0] blk1_vis;

   // ------------------------------------------------
   // Front end and bank switch
   // ------------------------------------------------
   quadrature_frontend u_frontend (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .en_i     (en_i),
      .data_i   (data_i),
      .valid_o  (valid),
      .sample_o (sample)
   );

   bank_switch #(.ACCUM_W(ACCUM_W)) u_switch (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .valid_i     (valid),
      .sums_i      (sums_i),
      .swap_o      (swap),
      .swap_seen_o (swap_o),            // Registered pulse to the host
      .bank_o      (bank_o)
   );

   // ------------------------------------------------
   // Correlator blocks
   // ------------------------------------------------
   correlator_block #(.ACCUM_W(ACCUM_W), .BLOCK_NUM(0)) u_block0 (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .valid_i  (valid),
      .swap_i   (swap),
      .sample_i (sample),
      .sel_i    (sel),
      .vis_o    (blk0_vis)
   );

   correlator_block #(.ACCUM_W(ACCUM_W), .BLOCK_NUM(1)) u_block1 (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .valid_i  (valid),
      .swap_i   (swap),
      .sample_i (sample),
      .sel_i    (sel),
      .vis_o    (blk1_vis)
   );

   // ------------------------------------------------
   // Read-back
   // ------------------------------------------------
   visibility_readout #(.ACCUM_W(ACCUM_W)) u_readout (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (req_i),
      .addr_i     (addr_i),
      .blk0_vis_i (blk0_vis),
      .blk1_vis_i (blk1_vis),
      .sel_o      (sel),
      .ack_o      (ack_o),
      .dat_o      (dat_o)
   );

endmodule

// File: rtl/visibility_readout.sv
module visibility_readout #(
   parameter int ACCUM_W = vis_pkg::ACCUM_W_DEFAULT
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               req_i,       // Four-phase request
   input  vis_pkg::vis_addr_t addr_i,      // Stable while req_i is high
   input  logic [ACCUM_W-1:0] blk0_vis_i,  // Block 0 selected value
   input  logic [ACCUM_W-1:0] blk1_vis_i,  // Block 1 selected value
   output vis_pkg::vis_sel_t  sel_o,       // Entry select to both blocks
   output logic               ack_o,       // Four-phase acknowledge
   output logic [ACCUM_W-1:0] dat_o        // Read data valid with ack_o
);

   import vis_pkg::*;

   typedef enum logic [1:0] {
      IDLE,                              // Wait for req_i
      FETCH,                             // Address out while blocks settle
      ACK,                               // First ack cycle
      RELEASE                            // Host still holds req_i
   } state_t;

   state_t    state_q;
   state_t    state_d;
   vis_addr_t addr_q;                    // Latched read address

   // ------------------------------------------------
   // Handshake FSM
   // ------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (req_i) state_d = FETCH;
         FETCH:   state_d = ACK;
         ACK:     state_d = req_i ? RELEASE : IDLE;
         RELEASE: if (!req_i) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign ack_o = (state_q == ACK) || (state_q == RELEASE);

   // ------------------------------------------------
   // Address and data registers
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && req_i) begin
         addr_q <= addr_i;               // Captured on the first req edge
      end
      if (state_q == FETCH) begin
         // Block bit picks the source for the whole ack phase
         dat_o <= addr_q[ADDR_BLK_BIT] ? blk1_vis_i : blk0_vis_i;
      end
   end

   assign sel_o = '{
      pair: pair_idx_t'(addr_q[ADDR_PAIR_LSB +: 2]),
      imag: addr_q[ADDR_IMAG_BIT]
   };

   // ------------------------------------------------
   // Protocol checks
   // ------------------------------------------------
   a_ack_needs_req: assert property (
      @(posedge clk_i) disable iff (reset_i)
      $rose(ack_o) |-> $past(req_i)
   ) else $error("visibility_readout: ack rose without a request");

endmodule

// File: rtl/correlator_block.sv
module correlator_block #(
   parameter int ACCUM_W   = vis_pkg::ACCUM_W_DEFAULT,
   parameter int BLOCK_NUM = 0
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               valid_i,    // Accumulate this cycle
   input  logic               swap_i,     // Last sample of the bank
   input  vis_pkg::sample_t   sample_i,   // Quadrature sample
   input  vis_pkg::vis_sel_t  sel_i,      // Readout entry to return
   output logic [ACCUM_W-1:0] vis_o       // Selected readout value
);

   import vis_pkg::*;

   typedef logic [ACCUM_W-1:0] vis_t;

   typedef struct packed {
      vis_t re;                          // Real count
      vis_t im;                          // Imaginary count
   } vis_pair_t;

   logic [PAIRS_PER_BLOCK-1:0] prod_re;   // Per-pair real product
   logic [PAIRS_PER_BLOCK-1:0] prod_im;   // Per-pair imaginary product
   vis_pair_t                  sum   [PAIRS_PER_BLOCK];  // acc + product
   vis_pair_t                  acc_q [PAIRS_PER_BLOCK];  // Running sums
   vis_pair_t                  bank_q[PAIRS_PER_BLOCK];  // Readout bank

   if (BLOCK_NUM < 0 || BLOCK_NUM >= BLOCK_COUNT) begin : g_bad_block
      $error("correlator_block: BLOCK_NUM out of range");
   end

   // ------------------------------------------------
   // Pair products
   // ------------------------------------------------
   // 1-bit correlation is an XNOR, a match counts one
   for (genvar p = 0; p < PAIRS_PER_BLOCK; p++) begin : g_pair
      localparam int ANT_A = pair_ant_a(BLOCK_NUM, p);
      localparam int ANT_B = pair_ant_b(BLOCK_NUM, p);

      assign prod_re[p] = ~(sample_i.re[ANT_A] ^ sample_i.re[ANT_B]);
      assign prod_im[p] = ~(sample_i.re[ANT_A] ^ sample_i.im[ANT_B]);

      assign sum[p].re  = acc_q[p].re + vis_t'(prod_re[p]);
      assign sum[p].im  = acc_q[p].im + vis_t'(prod_im[p]);
   end

   // ------------------------------------------------
   // Accumulators and readout bank
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int p = 0; p < PAIRS_PER_BLOCK; p++) begin
            acc_q[p]  <= '0;
            bank_q[p] <= '0;
         end
      end else if (valid_i) begin
         for (int p = 0; p < PAIRS_PER_BLOCK; p++) begin
            if (swap_i) begin
               bank_q[p] <= sum[p];      // Bank closes with this sample
               acc_q[p]  <= '0;          // Next bank starts empty
            end else begin
               acc_q[p]  <= sum[p];
            end
         end
      end
   end

   // ------------------------------------------------
   // Read mux
   // ------------------------------------------------
   // Pair index 3 matches no entry and returns zero
   always_comb begin
      vis_o = '0;
      for (int p = 0; p < PAIRS_PER_BLOCK; p++) begin
         if (sel_i.pair == pair_idx_t'(p)) begin
            vis_o = sel_i.imag ? bank_q[p].im : bank_q[p].re;
         end
      end
   end

   // Bank switch and front end must agree on sample timing,
   // otherwise a swap would drop the closing product
   a_swap_valid: assert property (
      @(posedge clk_i) disable iff (reset_i)
      swap_i |-> valid_i
   ) else $error("correlator_block: swap without a valid sample");

endmodule

// File: rtl/bank_switch.sv
module bank_switch #(
   parameter int ACCUM_W = vis_pkg::ACCUM_W_DEFAULT
) (
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               valid_i,      // Valid sample this cycle
   input  logic [ACCUM_W-1:0] sums_i,       // Nonzero samples per bank
   output logic               swap_o,       // Swap on this edge
   output logic               swap_seen_o,  // Swap delayed one cycle
   output vis_pkg::bank_t     bank_o        // Current bank index
);

   typedef logic [ACCUM_W-1:0] count_t;

   count_t count_q;                       // Valid samples since last swap
   count_t count_nxt;

   // ------------------------------------------------
   // Swap decode
   // ------------------------------------------------
   assign count_nxt = count_q + count_t'(1);
   // Combinational on the last sample of the bank so the
   // blocks fold this sample in at the same edge
   assign swap_o    = valid_i && (count_nxt == sums_i);

   // ------------------------------------------------
   // Counter and bank toggle
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_q     <= '0;
         swap_seen_o <= 1'b0;
         bank_o      <= 1'b0;
      end else begin
         swap_seen_o <= swap_o;          // Status pulse for the host
         if (swap_o) begin
            count_q <= '0;               // Restart for next bank
            bank_o  <= ~bank_o;
         end else if (valid_i) begin
            count_q <= count_nxt;
         end
      end
   end

   // A zero sums setting would let the counter wrap the
   // full range before swapping
   a_sums_nonzero: assert property (
      @(posedge clk_i) disable iff (reset_i)
      valid_i |-> (sums_i != '0)
   ) else $error("bank_switch: sums_i is zero with valid samples");

endmodule

// File: rtl/quadrature_frontend.sv
module quadrature_frontend (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              en_i,      // Sample strobe
   input  vis_pkg::antenna_t data_i,    // 1-bit antenna samples
   output logic              valid_o,   // Sample below is new
   output vis_pkg::sample_t  sample_o   // Real and delayed imaginary
);

   // ------------------------------------------------
   // Valid strobe
   // ------------------------------------------------
   // One cycle behind en_i, matches the sample register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= en_i;
      end
   end

   // ------------------------------------------------
   // Quadrature pair
   // ------------------------------------------------
   // The imaginary stream is the real stream one valid
   // sample late, a cheap stand-in for a Hilbert filter.
   // Both halves hold between enables so a gap in en_i
   // does not shift the delay.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sample_o.re <= '0;             // No history yet
         sample_o.im <= '0;             // im reads 0 before 1st sample
      end else if (en_i) begin
         sample_o.re <= data_i;         // New real part
         sample_o.im <= sample_o.re;    // Old real becomes imaginary
      end
   end

endmodule

// File: rtl/vis_pkg.sv
package vis_pkg;

   // ------------------------------------------------
   // Array geometry
   // ------------------------------------------------
   localparam int ANT_COUNT       = 4;   // Antennas in the array
   localparam int BLOCK_COUNT     = 2;   // Correlator blocks
   localparam int PAIRS_PER_BLOCK = 3;   // Pairs summed by each block
   localparam int ACCUM_W_DEFAULT = 16;  // Default accumulator width

   // Read address layout {blk, pair[1:0], imag}
   localparam int ADDR_BLK_BIT  = 3;     // Block number
   localparam int ADDR_PAIR_LSB = 1;     // Low bit of pair index
   localparam int ADDR_IMAG_BIT = 0;     // 0 real, 1 imaginary

   // ------------------------------------------------
   // Shared types
   // ------------------------------------------------
   typedef logic [ANT_COUNT-1:0] antenna_t;  // One bit per antenna

   typedef struct packed {
      antenna_t re;                      // Current valid sample
      antenna_t im;                      // Previous valid sample
   } sample_t;

   typedef logic [1:0] pair_idx_t;       // 3 is unused

   typedef struct packed {
      pair_idx_t pair;                   // Pair within block
      logic      imag;                   // Imaginary component
   } vis_sel_t;

   typedef logic [3:0] vis_addr_t;       // Host read address
   typedef logic       bank_t;           // Readout bank index

   // ------------------------------------------------
   // Pair table
   // ------------------------------------------------
   // Block 0 takes antenna 0 against 1..3
   // Block 1 takes the remaining (1,2) (1,3) (2,3)
   function automatic int pair_ant_a(input int blk, input int pair);
      if (blk == 0) return 0;
      return (pair == 2) ? 2 : 1;
   endfunction

   function automatic int pair_ant_b(input int blk, input int pair);
      if (blk == 0) return pair + 1;
      return (pair == 0) ? 2 : 3;
   endfunction

endpackage
